// ==== Bender.yml ====
package:
  name: uart_string_link

sources:
  - include_dirs:
      - logic
    files:
      - logic/uart_pkg.sv
      - logic/uart_tx.sv
      - logic/uart_rx.sv
      - logic/string_sender.sv
      - logic/string_receiver.sv
      - logic/uart_string_link.sv
  - target: test
    include_dirs:
      - logic
      - tb
    files:
      - tb/tb_uart_string_link.sv

// ==== all.f ====
+incdir+logic
+incdir+tb
logic/uart_pkg.sv
logic/uart_tx.sv
logic/uart_rx.sv
logic/string_sender.sv
logic/string_receiver.sv
logic/uart_string_link.sv
tb/tb_uart_string_link.sv

// ==== logic/string_receiver.sv ====
//********************
// frame parser for incoming strings
// strips the "&&" marks, reports content with rx_done or a fault with rx_err
//********************
`timescale 1ns/1ps

`include "uart_defs.svh"

module string_receiver (
	input  logic              sys_clk,
	input  logic              sys_rst_n,
	input  uart_pkg::byte_t   rx_byte,
	input  logic              rx_valid,
	output uart_pkg::rx_msg_t rx_msg,
	output logic              rx_done,
	output logic              rx_err
);

	import uart_pkg::*;

	localparam int IDLE_W = $clog2(`RX_IDLE_CLKS + 1);
	localparam logic [IDLE_W-1:0] IDLE_LAST = IDLE_W'(`RX_IDLE_CLKS - 1);

	recv_state_e       state;
	str_t              text_buf;
	len_t              cnt;
	logic [IDLE_W-1:0] idle_cnt;
	logic              is_mark;
	logic              timeout;

	assign is_mark = (rx_byte == `FRAME_MARK);

	// gap check only once a frame has begun
	assign timeout = (state != recv_hunt) && !rx_valid && (idle_cnt == IDLE_LAST);

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			idle_cnt <= '0;
		end else if (state == recv_hunt || rx_valid || timeout) begin
			idle_cnt <= '0;
		end else begin
			idle_cnt <= idle_cnt + 1'b1;
		end
	end

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			state   <= recv_hunt;
			cnt     <= '0;
			rx_msg  <= '0;
			rx_done <= 1'b0;
			rx_err  <= 1'b0;
		end else begin
			rx_done <= 1'b0;
			rx_err  <= 1'b0;
			if (timeout) begin
				state  <= recv_hunt;
				rx_err <= 1'b1;
			end else if (rx_valid) begin
				case (state)
					recv_hunt: begin
						if (is_mark) begin
							state <= recv_open2;
						end
					end
					recv_open2: begin
						// a lone mark followed by anything else is noise
						if (is_mark) begin
							state <= recv_body;
							cnt   <= '0;
						end else begin
							state <= recv_hunt;
						end
					end
					recv_body: begin
						if (is_mark) begin
							state <= recv_close2;
						end else if (cnt == len_t'(`STR_MAX_BYTES)) begin
							// buffer already full
							state  <= recv_hunt;
							rx_err <= 1'b1;
						end else begin
							cnt <= cnt + 1'b1;
						end
					end
					recv_close2: begin
						state <= recv_hunt;
						if (is_mark) begin
							rx_msg.text <= text_buf;
							rx_msg.len  <= cnt;
							rx_done     <= 1'b1;
						end else begin
							rx_err <= 1'b1;
						end
					end
					default: state <= recv_hunt;
				endcase
			end
		end
	end

	// content store, cleared when a frame opens so unused bytes read zero
	always_ff @(posedge sys_clk) begin
		if (rx_valid && state == recv_open2 && is_mark) begin
			text_buf <= '0;
		end else if (rx_valid && state == recv_body && !is_mark &&
				cnt != len_t'(`STR_MAX_BYTES)) begin
			text_buf[8*cnt +: 8] <= rx_byte;
		end
	end

endmodule

// ==== logic/string_sender.sv ====
//********************
// frame builder for outgoing strings
// sends "&&", len content bytes, "&&" through uart_tx per tx_start
//********************
`timescale 1ns/1ps

`include "uart_defs.svh"

module string_sender (
	input  logic              sys_clk,
	input  logic              sys_rst_n,
	input  uart_pkg::tx_req_t tx_req,
	input  logic              tx_start,
	input  logic              byte_sent,
	output uart_pkg::byte_t   byte_data,
	output logic              byte_start,
	output logic              tx_busy,
	output logic              tx_done
);

	import uart_pkg::*;

	send_state_e state;
	tx_req_t     req_q;
	// index of the next content byte
	len_t        byte_cnt;

	assign tx_busy = (state != send_idle);

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			state      <= send_idle;
			byte_cnt   <= '0;
			byte_start <= 1'b0;
			tx_done    <= 1'b0;
		end else begin
			byte_start <= 1'b0;
			tx_done    <= 1'b0;
			case (state)
				send_idle: begin
					if (tx_start) begin
						state      <= send_open1;
						byte_start <= 1'b1;
					end
				end
				send_open1: begin
					if (byte_sent) begin
						state      <= send_open2;
						byte_start <= 1'b1;
					end
				end
				send_open2: begin
					if (byte_sent) begin
						byte_start <= 1'b1;
						// empty string goes straight to the closing marks
						if (req_q.len == '0) begin
							state <= send_close1;
						end else begin
							state    <= send_body;
							byte_cnt <= len_t'(1);
						end
					end
				end
				send_body: begin
					if (byte_sent) begin
						byte_start <= 1'b1;
						if (byte_cnt == req_q.len) begin
							state <= send_close1;
						end else begin
							byte_cnt <= byte_cnt + 1'b1;
						end
					end
				end
				send_close1: begin
					if (byte_sent) begin
						state      <= send_close2;
						byte_start <= 1'b1;
					end
				end
				send_close2: begin
					if (byte_sent) begin
						state   <= send_idle;
						tx_done <= 1'b1;
					end
				end
				default: state <= send_idle;
			endcase
		end
	end

	// request and outgoing byte
	always_ff @(posedge sys_clk) begin
		if (state == send_idle && tx_start) begin
			req_q     <= tx_req;
			byte_data <= `FRAME_MARK;
		end else if (byte_sent) begin
			if (state == send_open2 && req_q.len != '0) begin
				byte_data <= req_q.text[7:0];
			end else if (state == send_body && byte_cnt != req_q.len) begin
				byte_data <= req_q.text[8*byte_cnt +: 8];
			end else begin
				byte_data <= `FRAME_MARK;
			end
		end
	end

endmodule

// ==== logic/uart_defs.svh ====
//********************
// rates, sizes and framing constants for the uart string link
// include wherever a module or the package needs them
//********************
`ifndef UART_DEFS_SVH
`define UART_DEFS_SVH

// system clock and line rate
`define UART_CLK_HZ 25_000_000
`define UART_BAUD 1_562_500
`define UART_CLKS_PER_BIT (`UART_CLK_HZ / `UART_BAUD)

// string capacity in bytes
`define STR_MAX_BYTES 32

// frame marker is ascii '&', sent twice at each end
`define FRAME_MARK 8'h26

// longest allowed gap between two bytes of a frame, four byte times
`define RX_IDLE_CLKS 640

`endif

// ==== logic/uart_pkg.sv ====
//********************
// shared types of the uart string link
// import inside the module body, or use scoped names in port lists
//********************
package uart_pkg;

	`include "uart_defs.svh"

	// one character on the line
	typedef logic [7:0] byte_t;

	// content length, 0 to STR_MAX_BYTES
	typedef logic [$clog2(`STR_MAX_BYTES + 1)-1:0] len_t;

	// string buffer, byte 0 in the low bits
	typedef logic [`STR_MAX_BYTES*8-1:0] str_t;

	// host send request
	typedef struct packed {
		str_t text;
		len_t len;
	} tx_req_t;

	// received frame content
	typedef struct packed {
		str_t text;
		len_t len;
	} rx_msg_t;

	typedef enum logic [2:0] {
		send_idle,
		send_open1,
		send_open2,
		send_body,
		send_close1,
		send_close2
	} send_state_e;

	typedef enum logic [1:0] {
		recv_hunt,
		recv_open2,
		recv_body,
		recv_close2
	} recv_state_e;

endpackage

// ==== logic/uart_rx.sv ====
//********************
// uart deserializer, 8n1
// two-flop synchronizer, mid-bit sampling, one rx_valid per good byte
//********************
`timescale 1ns/1ps

`include "uart_defs.svh"

module uart_rx (
	input  logic            sys_clk,
	input  logic            sys_rst_n,
	input  logic            rxd,
	output uart_pkg::byte_t rx_byte,
	output logic            rx_valid
);

	import uart_pkg::*;

	localparam int CNT_W = $clog2(`UART_CLKS_PER_BIT);
	localparam logic [CNT_W-1:0] HALF_BIT = CNT_W'(`UART_CLKS_PER_BIT / 2 - 1);
	localparam logic [CNT_W-1:0] FULL_BIT = CNT_W'(`UART_CLKS_PER_BIT - 1);
	localparam logic [3:0] STOP_IDX = 4'd9;

	logic             rxd_meta;
	logic             rxd_sync;
	logic             rxd_prev;
	logic             busy;
	logic [CNT_W-1:0] clk_cnt;
	logic [3:0]       bit_idx;
	logic             sample;
	byte_t            rx_shift;

	// half a bit for the start check, then a full bit to each data bit middle
	assign sample = (bit_idx == 4'd0) ? (clk_cnt == HALF_BIT) : (clk_cnt == FULL_BIT);

	assign rx_byte = rx_shift;

	// line idles high
	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			rxd_meta <= 1'b1;
			rxd_sync <= 1'b1;
			rxd_prev <= 1'b1;
		end else begin
			rxd_meta <= rxd;
			rxd_sync <= rxd_meta;
			rxd_prev <= rxd_sync;
		end
	end

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			busy     <= 1'b0;
			clk_cnt  <= '0;
			bit_idx  <= '0;
			rx_valid <= 1'b0;
		end else begin
			rx_valid <= 1'b0;
			if (!busy) begin
				clk_cnt <= '0;
				bit_idx <= '0;
				// falling edge of a start bit
				if (rxd_prev && !rxd_sync) begin
					busy <= 1'b1;
				end
			end else if (sample) begin
				clk_cnt <= '0;
				bit_idx <= bit_idx + 4'd1;
				if (bit_idx == 4'd0) begin
					// glitch, not a real start bit
					if (rxd_sync) begin
						busy <= 1'b0;
					end
				end else if (bit_idx == STOP_IDX) begin
					busy     <= 1'b0;
					// low stop bit drops the byte
					rx_valid <= rxd_sync;
				end
			end else begin
				clk_cnt <= clk_cnt + 1'b1;
			end
		end
	end

	// data bits arrive lsb first
	always_ff @(posedge sys_clk) begin
		if (busy && sample && (bit_idx inside {[4'd1:4'd8]})) begin
			rx_shift <= {rxd_sync, rx_shift[7:1]};
		end
	end

endmodule

// ==== logic/uart_string_link.sv ====
//********************
// uart string link top level
// host strings out as &&text&& on uart_tx_port, frames in from uart_rx_port
//********************
`timescale 1ns/1ps

module uart_string_link (
	input  logic              sys_clk,
	input  logic              sys_rst_n,
	input  uart_pkg::tx_req_t tx_req,
	input  logic              tx_start,
	output logic              tx_busy,
	output logic              tx_done,
	output uart_pkg::rx_msg_t rx_msg,
	output logic              rx_done,
	output logic              rx_err,
	input  logic              uart_rx_port,
	output logic              uart_tx_port
);

	import uart_pkg::*;

	// transmit path
	byte_t byte_data;
	logic  byte_start;
	logic  byte_sent;

	// receive path
	byte_t rx_byte;
	logic  rx_valid;

	string_sender i_string_sender (
		.sys_clk    (sys_clk),
		.sys_rst_n  (sys_rst_n),
		.tx_req     (tx_req),
		.tx_start   (tx_start),
		.byte_sent  (byte_sent),
		.byte_data  (byte_data),
		.byte_start (byte_start),
		.tx_busy    (tx_busy),
		.tx_done    (tx_done)
	);

	uart_tx i_uart_tx (
		.sys_clk    (sys_clk),
		.sys_rst_n  (sys_rst_n),
		.byte_data  (byte_data),
		.byte_start (byte_start),
		.txd        (uart_tx_port),
		.byte_sent  (byte_sent)
	);

	uart_rx i_uart_rx (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.rxd       (uart_rx_port),
		.rx_byte   (rx_byte),
		.rx_valid  (rx_valid)
	);

	string_receiver i_string_receiver (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.rx_byte   (rx_byte),
		.rx_valid  (rx_valid),
		.rx_msg    (rx_msg),
		.rx_done   (rx_done),
		.rx_err    (rx_err)
	);

endmodule

// ==== logic/uart_tx.sv ====
//********************
// uart serializer, 8n1
// one byte per byte_start strobe, ignored while a byte is on the line
//********************
`timescale 1ns/1ps

`include "uart_defs.svh"

module uart_tx (
	input  logic            sys_clk,
	input  logic            sys_rst_n,
	input  uart_pkg::byte_t byte_data,
	input  logic            byte_start,
	output logic            txd,
	output logic            byte_sent
);

	localparam int CNT_W = $clog2(`UART_CLKS_PER_BIT);
	localparam logic [CNT_W-1:0] FULL_BIT = CNT_W'(`UART_CLKS_PER_BIT - 1);
	// start bit is index 0, stop bit index 9
	localparam logic [3:0] STOP_IDX = 4'd9;

	logic             busy;
	logic [CNT_W-1:0] clk_cnt;
	logic [3:0]       bit_idx;
	// data bits followed by the stop bit, shifted out lsb first
	logic [8:0]       tx_shift;
	logic             bit_end;

	assign bit_end = (clk_cnt == FULL_BIT);

	// last cycle of the stop bit
	assign byte_sent = busy && bit_end && (bit_idx == STOP_IDX);

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			busy    <= 1'b0;
			txd     <= 1'b1;
			clk_cnt <= '0;
			bit_idx <= '0;
		end else if (!busy) begin
			clk_cnt <= '0;
			bit_idx <= '0;
			if (byte_start) begin
				busy <= 1'b1;
				// start bit goes out right away
				txd  <= 1'b0;
			end
		end else if (bit_end) begin
			clk_cnt <= '0;
			if (bit_idx == STOP_IDX) begin
				busy <= 1'b0;
				txd  <= 1'b1;
			end else begin
				bit_idx <= bit_idx + 4'd1;
				txd     <= tx_shift[0];
			end
		end else begin
			clk_cnt <= clk_cnt + 1'b1;
		end
	end

	always_ff @(posedge sys_clk) begin
		if (!busy && byte_start) begin
			tx_shift <= {1'b1, byte_data};
		end else if (busy && bit_end) begin
			tx_shift <= {1'b1, tx_shift[8:1]};
		end
	end

endmodule

// ==== tb/tb_uart_tasks.svh ====
//********************
// serial line driver and monitor for the string link testbench
// included inside the testbench module, uses its clock and line signals
//********************
`ifndef TB_UART_TASKS_SVH
`define TB_UART_TASKS_SVH

// one 8n1 byte on drv_line, lsb first, each bit held one bit time
task automatic drive_byte(input byte_t value);
	logic [9:0] frame;
	frame = {1'b1, value, 1'b0};
	for (int i = 0; i < 10; i++) begin
		drv_line = frame[i];
		repeat (`UART_CLKS_PER_BIT) @(negedge sys_clk);
	end
endtask

task automatic drive_idle(input int cycles);
	drv_line = 1'b1;
	repeat (cycles) @(negedge sys_clk);
endtask

// whole byte stream, with an over-long gap before byte gap_at if it is not -1
task automatic drive_stream(input string bytes, input int gap_at);
	for (int i = 0; i < bytes.len(); i++) begin
		if (i == gap_at) begin
			drive_idle(`RX_IDLE_CLKS + 100);
		end
		drive_byte(bytes[i]);
	end
endtask

// decodes one byte from uart_tx_port, ok low on a missing or malformed byte
task automatic capture_byte(output byte_t value, output bit ok);
	int wait_cnt;
	ok       = 1'b0;
	value    = '0;
	wait_cnt = 0;
	while (uart_tx_port !== 1'b0 && wait_cnt < 40 * `UART_CLKS_PER_BIT) begin
		@(negedge sys_clk);
		wait_cnt++;
	end
	if (uart_tx_port !== 1'b0) begin
		return;
	end
	// move to the middle of the start bit
	repeat (`UART_CLKS_PER_BIT / 2 - 1) @(negedge sys_clk);
	if (uart_tx_port !== 1'b0) begin
		return;
	end
	for (int i = 0; i < 8; i++) begin
		repeat (`UART_CLKS_PER_BIT) @(negedge sys_clk);
		value[i] = uart_tx_port;
	end
	repeat (`UART_CLKS_PER_BIT) @(negedge sys_clk);
	ok = (uart_tx_port === 1'b1);
endtask

// expects two marks, len content bytes and two marks on uart_tx_port
task automatic capture_frame(input string name, input str_t text, input len_t len);
	int    total;
	byte_t got;
	byte_t exp_byte;
	bit    ok;
	total = int'(len) + 4;
	for (int k = 0; k < total; k++) begin
		capture_byte(got, ok);
		if (!ok) begin
			report_failure($sformatf("%s: frame on uart_tx_port broken at byte %0d", name, k));
			break;
		end
		if (k < 2 || k >= total - 2) begin
			exp_byte = `FRAME_MARK;
		end else begin
			exp_byte = text[8*(k-2) +: 8];
		end
		check_value($sformatf("%s byte %0d", name, k), exp_byte, got);
	end
endtask

`endif

// ==== tb/tb_uart_string_link.sv ====
//********************
// testbench for the uart string link
// send rows loop the line back and raw rows drive the receive line directly
//********************
`timescale 1ns/1ps

`include "uart_defs.svh"

module tb_uart_string_link;

	import uart_pkg::*;

	localparam int MAX_ROWS = 16;

	logic    sys_clk;
	logic    sys_rst_n;
	tx_req_t tx_req;
	logic    tx_start;
	logic    tx_busy;
	logic    tx_done;
	rx_msg_t rx_msg;
	logic    rx_done;
	logic    rx_err;
	logic    uart_rx_port;
	logic    uart_tx_port;
	logic    drv_line;
	logic    loopback;

	int          error_cnt   = 0;
	int          check_cnt   = 0;
	int          tx_done_cnt = 0;
	int          rx_done_cnt = 0;
	int          rx_err_cnt  = 0;
	int          num_rows    = 0;
	int unsigned seed_val;

	// stimulus table with one entry per row
	string row_name     [MAX_ROWS];
	bit    row_raw      [MAX_ROWS];
	string row_stream   [MAX_ROWS];
	str_t  row_text     [MAX_ROWS];
	len_t  row_len      [MAX_ROWS];
	int    row_gap_at   [MAX_ROWS];
	bit    row_double   [MAX_ROWS];
	bit    row_exp_done [MAX_ROWS];
	bit    row_exp_err  [MAX_ROWS];

	uart_string_link i_dut (
		.sys_clk      (sys_clk),
		.sys_rst_n    (sys_rst_n),
		.tx_req       (tx_req),
		.tx_start     (tx_start),
		.tx_busy      (tx_busy),
		.tx_done      (tx_done),
		.rx_msg       (rx_msg),
		.rx_done      (rx_done),
		.rx_err       (rx_err),
		.uart_rx_port (uart_rx_port),
		.uart_tx_port (uart_tx_port)
	);

	assign uart_rx_port = loopback ? uart_tx_port : drv_line;

	initial begin
		sys_clk = 1'b0;
		forever #20 sys_clk = ~sys_clk;
	end

	// strobe counters sampled on the quiet edge
	always @(negedge sys_clk) begin
		if (tx_done === 1'b1) tx_done_cnt++;
		if (rx_done === 1'b1) rx_done_cnt++;
		if (rx_err === 1'b1) rx_err_cnt++;
	end

	`include "tb_uart_tasks.svh"

	task automatic report_failure(input string msg);
		error_cnt++;
		$display("%s", msg);
	endtask

	task automatic check_value(input string name, input logic [255:0] expected,
			input logic [255:0] actual);
		check_cnt++;
		if (actual !== expected) begin
			error_cnt++;
			$display("error %s: expected %0h, got %0h", name, expected, actual);
		end
	endtask

	// byte i of the string lands in bits 8i+7..8i
	function automatic str_t to_text(input string s);
		str_t v;
		v = '0;
		for (int i = 0; i < s.len(); i++) begin
			v[8*i +: 8] = s[i];
		end
		return v;
	endfunction

	// characters 0x30 to 0x7a so never the mark
	function automatic str_t rand_text(input int n);
		str_t v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			v[8*i +: 8] = 8'h30 + 8'($urandom % 75);
		end
		return v;
	endfunction

	task automatic add_row(input string name, input bit raw, input string stream,
			input str_t text, input int len, input int gap_at, input bit double_start,
			input bit exp_done, input bit exp_err);
		row_name[num_rows]     = name;
		row_raw[num_rows]      = raw;
		row_stream[num_rows]   = stream;
		row_text[num_rows]     = text;
		row_len[num_rows]      = len_t'(len);
		row_gap_at[num_rows]   = gap_at;
		row_double[num_rows]   = double_start;
		row_exp_done[num_rows] = exp_done;
		row_exp_err[num_rows]  = exp_err;
		num_rows++;
	endtask

	// name, raw, raw stream, content, len, gap before byte, second start, done, err
	task automatic load_table();
		add_row("empty", 0, "", '0, 0, -1, 0, 1, 0);
		add_row("single", 0, "", to_text("Z"), 1, -1, 0, 1, 0);
		add_row("rand17", 0, "", rand_text(17), 17, -1, 0, 1, 0);
		add_row("rand32", 0, "", rand_text(32), 32, -1, 0, 1, 0);
		add_row("busy_start", 0, "", to_text("busy"), 4, -1, 1, 1, 0);
		add_row("noise_frame", 1, "xy&z&&hello&&", to_text("hello"), 5, -1, 0, 1, 0);
		add_row("bad_close", 1, "&&abc&x", '0, 0, -1, 0, 0, 1);
		add_row("overflow", 1, "&&abcdefghijklmnopqrstuvwxyz0123456", '0, 0, -1, 0, 0, 1);
		// timeout inside the first body and then a clean frame
		add_row("gap_timeout", 1, "&&ab&&ok&&", to_text("ok"), 2, 4, 0, 1, 1);
	endtask

	task automatic wait_for_strobes(input int tx_target, input int rx_target,
			input int err_target, input int limit);
		int n;
		n = 0;
		while (!(tx_done_cnt >= tx_target && rx_done_cnt >= rx_target &&
				rx_err_cnt >= err_target) && n < limit) begin
			@(negedge sys_clk);
			n++;
		end
		if (n >= limit) begin
			report_failure("timeout waiting for done or error strobes");
		end
	endtask

	task automatic watch_line_idle(input string name, input int cycles);
		for (int n = 0; n < cycles; n++) begin
			@(negedge sys_clk);
			if (uart_tx_port !== 1'b1) begin
				report_failure($sformatf("%s: unexpected second frame on uart_tx_port", name));
				break;
			end
		end
	endtask

	// a new request while busy must be dropped
	task automatic retry_start(input string name);
		repeat (3) @(negedge sys_clk);
		check_value($sformatf("%s tx_busy", name), 1, tx_busy);
		tx_req.text = to_text("zzzz");
		tx_req.len  = len_t'(4);
		tx_start    = 1'b1;
		@(negedge sys_clk);
		tx_start = 1'b0;
	endtask

	task automatic run_send_row(input int r);
		int tx_base;
		int rx_base;
		int err_base;
		tx_base     = tx_done_cnt;
		rx_base     = rx_done_cnt;
		err_base    = rx_err_cnt;
		loopback    = 1'b1;
		tx_req.text = row_text[r];
		tx_req.len  = row_len[r];
		tx_start    = 1'b1;
		@(negedge sys_clk);
		tx_start = 1'b0;
		fork
			capture_frame(row_name[r], row_text[r], row_len[r]);
			begin
				if (row_double[r]) retry_start(row_name[r]);
			end
		join
		wait_for_strobes(tx_base + 1, rx_base + row_exp_done[r],
				err_base + row_exp_err[r], 4000);
		watch_line_idle(row_name[r], 400);
		check_value($sformatf("%s tx_done", row_name[r]), 1, tx_done_cnt - tx_base);
		check_value($sformatf("%s rx_done", row_name[r]), row_exp_done[r],
				rx_done_cnt - rx_base);
		check_value($sformatf("%s rx_err", row_name[r]), row_exp_err[r],
				rx_err_cnt - err_base);
		check_value($sformatf("%s len", row_name[r]), row_len[r], rx_msg.len);
		check_value($sformatf("%s text", row_name[r]), row_text[r], rx_msg.text);
	endtask

	task automatic run_raw_row(input int r);
		int rx_base;
		int err_base;
		rx_base  = rx_done_cnt;
		err_base = rx_err_cnt;
		loopback = 1'b0;
		drive_stream(row_stream[r], row_gap_at[r]);
		wait_for_strobes(0, rx_base + row_exp_done[r], err_base + row_exp_err[r], 2000);
		// long enough for a stray idle timeout to show up
		drive_idle(`RX_IDLE_CLKS + 200);
		check_value($sformatf("%s rx_done", row_name[r]), row_exp_done[r],
				rx_done_cnt - rx_base);
		check_value($sformatf("%s rx_err", row_name[r]), row_exp_err[r],
				rx_err_cnt - err_base);
		if (row_exp_done[r]) begin
			check_value($sformatf("%s len", row_name[r]), row_len[r], rx_msg.len);
			check_value($sformatf("%s text", row_name[r]), row_text[r], rx_msg.text);
		end
	endtask

	initial begin
		sys_rst_n = 1'b0;
		tx_req    = '0;
		tx_start  = 1'b0;
		drv_line  = 1'b1;
		loopback  = 1'b0;
		seed_val  = $urandom(27167);
		load_table();
		repeat (4) @(negedge sys_clk);
		sys_rst_n = 1'b1;
		repeat (4) @(negedge sys_clk);
		for (int r = 0; r < num_rows; r++) begin
			if (row_raw[r]) begin
				run_raw_row(r);
			end else begin
				run_send_row(r);
			end
		end
		$display("rows: %0d, checks: %0d, errors: %0d", num_rows, check_cnt, error_cnt);
		if (error_cnt == 0) begin
			$display("PASS: all tests");
		end else begin
			$display("FAIL: see errors above");
		end
		$finish;
	end

endmodule
